//--- hwpe_cfg.svh
// Build-time constants for the HWPE subsystem
// Included by the packages and by any module that sizes ports from them
`ifndef HWPE_CFG_SVH
`define HWPE_CFG_SVH

// Engines and event targets
`define HWPE_NUM_ENGINES 2
`define HWPE_N_CORES     4

// Bus widths
`define HWPE_ID_WIDTH    4
`define HWPE_AW          32
`define HWPE_DW          32
`define HWPE_LEN_WIDTH   8

// Register index sits on address bits 4..2
`define HWPE_REG_LSB     2
`define HWPE_REG_MSB     4

`endif

//--- hwpe_bus_pkg.sv
// Field types of the configuration bus and the memory master port
// Ports use them by scoped name, module bodies by wildcard import
`include "hwpe_cfg.svh"

package hwpe_bus_pkg;

  // Address and data words
  typedef logic [`HWPE_AW-1:0] addr_t;
  typedef logic [`HWPE_DW-1:0] data_t;

  // Configuration transaction id, echoed on the response
  typedef logic [`HWPE_ID_WIDTH-1:0] id_t;

  // Engine select
  typedef logic [$clog2(`HWPE_NUM_ENGINES)-1:0] sel_t;

  // One event pair per core
  // bit 0 is job done, bit 1 is reserved and held at zero
  typedef logic [1:0] evt_t;

endpackage

//--- hwpe_job_pkg.sv
// Job description types of the reduction engine
// Opcodes, the register map and the two views of register 0
package hwpe_job_pkg;

  typedef enum logic [1:0] {
    SUM = 2'd0,
    XOR = 2'd1,
    MAX = 2'd2
  } opcode_e;

  // Word index inside the engine register window
  typedef enum logic [2:0] {
    REG_CMD = 3'd0,
    REG_SRC = 3'd1,
    REG_LEN = 3'd2,
    REG_DST = 3'd3
  } reg_idx_e;

  // Register 0 as written: a command
  typedef struct packed {
    logic [28:0] pad;
    opcode_e     opcode;
    logic        start;
  } reg0_cmd_t;

  // Register 0 as read: engine status
  typedef struct packed {
    logic [20:0] pad;
    logic [7:0]  count;
    opcode_e     opcode;
    logic        busy;
  } reg0_status_t;

  typedef union packed {
    reg0_cmd_t    cmd;
    reg0_status_t status;
  } reg0_u;

endpackage

//--- hwpe_ctrl_fsm.sv
// Job sequencer of one reduction engine
// Clears the accumulator, issues one read at a time, writes the result
// and pulses done for one cycle as busy drops
`timescale 1ns/1ps

module hwpe_ctrl_fsm (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic last_i,
  input  logic mem_gnt_i,
  input  logic mem_rvalid_i,
  output logic rd_req_o,
  output logic wr_req_o,
  output logic acc_clr_o,
  output logic acc_en_o,
  output logic cnt_step_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [2:0] {IDLE, READ, WAIT, WRITE, DONE} state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    acc_clr_o  = 1'b0;
    acc_en_o   = 1'b0;
    cnt_step_o = 1'b0;
    case (state_q)
      // DONE is already idle, so a start there is taken as well
      IDLE, DONE: begin
        state_d = IDLE;
        if (start_i) begin
          acc_clr_o = 1'b1;
          state_d   = last_i ? WRITE : READ;
        end
      end
      READ: begin
        if (mem_gnt_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (mem_rvalid_i) begin
          acc_en_o   = 1'b1;
          cnt_step_o = 1'b1;
          state_d    = last_i ? WRITE : READ;
        end
      end
      WRITE: begin
        if (mem_gnt_i) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign rd_req_o = (state_q == READ);
  assign wr_req_o = (state_q == WRITE);
  assign busy_o   = (state_q == READ) || (state_q == WAIT) || (state_q == WRITE);
  assign done_o   = (state_q == DONE);

endmodule

//--- hwpe_word_counter.sv
// Read address and remaining-word counter of one job
// Loaded at start, stepped once per returned word
`timescale 1ns/1ps
`include "hwpe_cfg.svh"

module hwpe_word_counter (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       load_i,
  input  logic                       step_i,
  input  hwpe_bus_pkg::addr_t        base_i,
  input  logic [`HWPE_LEN_WIDTH-1:0] len_i,
  output hwpe_bus_pkg::addr_t        addr_o,
  output logic                       last_o,
  output logic                       empty_o
);

  import hwpe_bus_pkg::*;

  logic [`HWPE_LEN_WIDTH-1:0] rem_q;
  logic [`HWPE_LEN_WIDTH-1:0] rem_cur;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_o <= '0;
      rem_q  <= '0;
    end else if (load_i) begin
      addr_o <= base_i;
      rem_q  <= len_i;
    end else if (step_i) begin
      addr_o <= addr_o + addr_t'(4);
      rem_q  <= rem_q - 1'b1;
    end
  end

  // Look through to the new length while loading, so a zero-length job is seen at start
  assign rem_cur = load_i ? len_i : rem_q;
  assign empty_o = (rem_cur == '0);
  assign last_o  = (rem_cur == `HWPE_LEN_WIDTH'(1));

endmodule

//--- hwpe_reduce_engine.sv
// Reduction engine: gated clock, job registers, accumulator and sequencer
// Reads LEN words from SRC, folds them by opcode and writes the result to DST
`timescale 1ns/1ps
`include "hwpe_cfg.svh"

module hwpe_reduce_engine (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                test_mode_i,
  input  logic                en_i,
  input  logic                cfg_req_i,
  input  logic                cfg_we_i,
  input  hwpe_bus_pkg::addr_t cfg_addr_i,
  input  hwpe_bus_pkg::data_t cfg_wdata_i,
  input  hwpe_bus_pkg::id_t   cfg_id_i,
  output logic                cfg_gnt_o,
  output hwpe_bus_pkg::data_t cfg_rdata_o,
  output logic                cfg_rvalid_o,
  output hwpe_bus_pkg::id_t   cfg_rid_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output hwpe_bus_pkg::addr_t mem_addr_o,
  output hwpe_bus_pkg::data_t mem_wdata_o,
  input  logic                mem_gnt_i,
  input  hwpe_bus_pkg::data_t mem_rdata_i,
  input  logic                mem_rvalid_i,
  output logic                busy_o,
  output logic                done_o
);

  import hwpe_bus_pkg::*;
  import hwpe_job_pkg::*;

  logic                       en_latch;
  logic                       gclk;
  reg_idx_e                   reg_idx;
  reg0_u                      cmd_w;
  reg0_u                      status_r;
  logic                       wr_en;
  logic                       start;
  addr_t                      src_q;
  addr_t                      dst_q;
  logic [`HWPE_LEN_WIDTH-1:0] len_q;
  opcode_e                    op_q;
  logic [7:0]                 jobs_q;
  data_t                      acc_q;
  data_t                      rdata_d;
  logic                       rd_req;
  logic                       wr_req;
  logic                       acc_clr;
  logic                       acc_en;
  logic                       cnt_step;
  logic                       cnt_last;
  logic                       cnt_empty;
  logic                       fsm_last;
  addr_t                      cnt_addr;

  //////////////////////////////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////////////////////////////

  // Enable sampled while clk is low, so gclk never glitches
  always_latch begin
    if (!clk) begin
      en_latch = en_i | test_mode_i;
    end
  end

  assign gclk = clk & en_latch;

  //////////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////////

  assign reg_idx   = reg_idx_e'(cfg_addr_i[`HWPE_REG_MSB:`HWPE_REG_LSB]);
  assign cmd_w     = cfg_wdata_i;
  assign cfg_gnt_o = cfg_req_i;
  assign wr_en     = cfg_req_i & cfg_we_i;
  // Start while busy is dropped
  assign start     = wr_en & (reg_idx == REG_CMD) & cmd_w.cmd.start & ~busy_o;

  always_comb begin
    status_r               = '0;
    status_r.status.busy   = busy_o;
    status_r.status.opcode = op_q;
    status_r.status.count  = jobs_q;
    case (reg_idx)
      REG_CMD: rdata_d = status_r;
      REG_SRC: rdata_d = src_q;
      REG_LEN: rdata_d = data_t'(len_q);
      REG_DST: rdata_d = dst_q;
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge gclk) begin
    cfg_rdata_o <= rdata_d;
    cfg_rid_o   <= cfg_id_i;
    if (wr_en) begin
      case (reg_idx)
        REG_SRC: src_q <= cfg_wdata_i;
        REG_LEN: len_q <= cfg_wdata_i[`HWPE_LEN_WIDTH-1:0];
        REG_DST: dst_q <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge gclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_rvalid_o <= 1'b0;
      op_q         <= SUM;
      jobs_q       <= '0;
    end else begin
      // Every granted request gets a response one cycle later
      cfg_rvalid_o <= cfg_req_i;
      if (start) begin
        op_q <= cmd_w.cmd.opcode;
      end
      if (done_o) begin
        jobs_q <= jobs_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Datapath and sequencing
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gclk) begin
    if (acc_clr) begin
      acc_q <= '0;
    end else if (acc_en) begin
      case (op_q)
        SUM:     acc_q <= acc_q + mem_rdata_i;
        XOR:     acc_q <= acc_q ^ mem_rdata_i;
        MAX:     acc_q <= (mem_rdata_i > acc_q) ? mem_rdata_i : acc_q;
        default: acc_q <= acc_q;
      endcase
    end
  end

  // Idle: a zero count ends the job at once. Busy: the returning word is the last
  assign fsm_last = busy_o ? cnt_last : cnt_empty;

  hwpe_ctrl_fsm u_fsm (
    .clk          (gclk),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .last_i       (fsm_last),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .rd_req_o     (rd_req),
    .wr_req_o     (wr_req),
    .acc_clr_o    (acc_clr),
    .acc_en_o     (acc_en),
    .cnt_step_o   (cnt_step),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  hwpe_word_counter u_cnt (
    .clk     (gclk),
    .rst_n_i (rst_n_i),
    .load_i  (start),
    .step_i  (cnt_step),
    .base_i  (src_q),
    .len_i   (len_q),
    .addr_o  (cnt_addr),
    .last_o  (cnt_last),
    .empty_o (cnt_empty)
  );

  assign mem_req_o   = rd_req | wr_req;
  assign mem_we_o    = wr_req;
  assign mem_addr_o  = wr_req ? dst_q : cnt_addr;
  assign mem_wdata_o = acc_q;

endmodule

//--- hwpe_sel_router.sv
// Engine select router
// Steers the config bus and the memory port to the selected engine and
// returns its responses, busy and done event
`timescale 1ns/1ps
`include "hwpe_cfg.svh"

module hwpe_sel_router (
  input  logic                                        hwpe_en_i,
  input  hwpe_bus_pkg::sel_t                          hwpe_sel_i,
  // Outside config bus
  input  logic                                        cfg_req_i,
  input  logic                                        cfg_we_i,
  input  hwpe_bus_pkg::addr_t                         cfg_addr_i,
  input  hwpe_bus_pkg::data_t                         cfg_wdata_i,
  input  hwpe_bus_pkg::id_t                           cfg_id_i,
  output logic                                        cfg_gnt_o,
  output hwpe_bus_pkg::data_t                         cfg_rdata_o,
  output logic                                        cfg_rvalid_o,
  output hwpe_bus_pkg::id_t                           cfg_rid_o,
  // Outside memory port
  output logic                                        mem_req_o,
  output logic                                        mem_we_o,
  output hwpe_bus_pkg::addr_t                         mem_addr_o,
  output hwpe_bus_pkg::data_t                         mem_wdata_o,
  input  logic                                        mem_gnt_i,
  input  hwpe_bus_pkg::data_t                         mem_rdata_i,
  input  logic                                        mem_rvalid_i,
  output hwpe_bus_pkg::evt_t [`HWPE_N_CORES-1:0]      evt_o,
  output logic                                        busy_o,
  // Engine side
  output logic [`HWPE_NUM_ENGINES-1:0]                eng_en_o,
  output logic [`HWPE_NUM_ENGINES-1:0]                eng_cfg_req_o,
  output logic [`HWPE_NUM_ENGINES-1:0]                eng_cfg_we_o,
  output hwpe_bus_pkg::addr_t [`HWPE_NUM_ENGINES-1:0] eng_cfg_addr_o,
  output hwpe_bus_pkg::data_t [`HWPE_NUM_ENGINES-1:0] eng_cfg_wdata_o,
  output hwpe_bus_pkg::id_t [`HWPE_NUM_ENGINES-1:0]   eng_cfg_id_o,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_cfg_gnt_i,
  input  hwpe_bus_pkg::data_t [`HWPE_NUM_ENGINES-1:0] eng_cfg_rdata_i,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_cfg_rvalid_i,
  input  hwpe_bus_pkg::id_t [`HWPE_NUM_ENGINES-1:0]   eng_cfg_rid_i,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_mem_req_i,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_mem_we_i,
  input  hwpe_bus_pkg::addr_t [`HWPE_NUM_ENGINES-1:0] eng_mem_addr_i,
  input  hwpe_bus_pkg::data_t [`HWPE_NUM_ENGINES-1:0] eng_mem_wdata_i,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_busy_i,
  input  logic [`HWPE_NUM_ENGINES-1:0]                eng_done_i,
  output logic [`HWPE_NUM_ENGINES-1:0]                eng_mem_gnt_o,
  output hwpe_bus_pkg::data_t [`HWPE_NUM_ENGINES-1:0] eng_mem_rdata_o,
  output logic [`HWPE_NUM_ENGINES-1:0]                eng_mem_rvalid_o
);

  import hwpe_bus_pkg::*;

  logic [`HWPE_NUM_ENGINES-1:0] sel_hit;

  // Select decode, request fields fan out unchanged
  for (genvar i = 0; i < `HWPE_NUM_ENGINES; i++) begin : gen_eng
    assign sel_hit[i]          = (hwpe_sel_i == sel_t'(i));
    assign eng_en_o[i]         = hwpe_en_i & sel_hit[i];
    assign eng_cfg_req_o[i]    = cfg_req_i & sel_hit[i];
    assign eng_cfg_we_o[i]     = cfg_we_i;
    assign eng_cfg_addr_o[i]   = cfg_addr_i;
    assign eng_cfg_wdata_o[i]  = cfg_wdata_i;
    assign eng_cfg_id_o[i]     = cfg_id_i;
    // Unselected engine never sees a memory handshake
    assign eng_mem_gnt_o[i]    = mem_gnt_i & sel_hit[i];
    assign eng_mem_rvalid_o[i] = mem_rvalid_i & sel_hit[i];
    assign eng_mem_rdata_o[i]  = mem_rdata_i;
  end

  // Responses from the selected engine
  assign cfg_gnt_o    = eng_cfg_gnt_i[hwpe_sel_i];
  assign cfg_rdata_o  = eng_cfg_rdata_i[hwpe_sel_i];
  assign cfg_rvalid_o = eng_cfg_rvalid_i[hwpe_sel_i];
  assign cfg_rid_o    = eng_cfg_rid_i[hwpe_sel_i];
  assign busy_o       = eng_busy_i[hwpe_sel_i];

  assign mem_req_o    = eng_mem_req_i[hwpe_sel_i];
  assign mem_we_o     = eng_mem_we_i[hwpe_sel_i];
  assign mem_addr_o   = eng_mem_addr_i[hwpe_sel_i];
  assign mem_wdata_o  = eng_mem_wdata_i[hwpe_sel_i];

  // Done goes to every core
  for (genvar c = 0; c < `HWPE_N_CORES; c++) begin : gen_evt
    assign evt_o[c] = {1'b0, eng_done_i[hwpe_sel_i]};
  end

endmodule

//--- hwpe_subsystem.sv
// HWPE subsystem top level
// Two reduction engines behind one config bus and one memory master port
`timescale 1ns/1ps
`include "hwpe_cfg.svh"

module hwpe_subsystem (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   test_mode_i,
  input  logic                                   hwpe_en_i,
  input  hwpe_bus_pkg::sel_t                     hwpe_sel_i,
  input  logic                                   cfg_req_i,
  input  logic                                   cfg_we_i,
  input  hwpe_bus_pkg::addr_t                    cfg_addr_i,
  input  hwpe_bus_pkg::data_t                    cfg_wdata_i,
  input  hwpe_bus_pkg::id_t                      cfg_id_i,
  output logic                                   cfg_gnt_o,
  output hwpe_bus_pkg::data_t                    cfg_rdata_o,
  output logic                                   cfg_rvalid_o,
  output hwpe_bus_pkg::id_t                      cfg_rid_o,
  output logic                                   mem_req_o,
  output logic                                   mem_we_o,
  output hwpe_bus_pkg::addr_t                    mem_addr_o,
  output hwpe_bus_pkg::data_t                    mem_wdata_o,
  input  logic                                   mem_gnt_i,
  input  hwpe_bus_pkg::data_t                    mem_rdata_i,
  input  logic                                   mem_rvalid_i,
  output hwpe_bus_pkg::evt_t [`HWPE_N_CORES-1:0] evt_o,
  output logic                                   busy_o
);

  import hwpe_bus_pkg::*;

  localparam int NE = `HWPE_NUM_ENGINES;

  logic [NE-1:0]  eng_en;
  logic [NE-1:0]  eng_cfg_req;
  logic [NE-1:0]  eng_cfg_we;
  addr_t [NE-1:0] eng_cfg_addr;
  data_t [NE-1:0] eng_cfg_wdata;
  id_t [NE-1:0]   eng_cfg_id;
  logic [NE-1:0]  eng_cfg_gnt;
  data_t [NE-1:0] eng_cfg_rdata;
  logic [NE-1:0]  eng_cfg_rvalid;
  id_t [NE-1:0]   eng_cfg_rid;
  logic [NE-1:0]  eng_mem_req;
  logic [NE-1:0]  eng_mem_we;
  addr_t [NE-1:0] eng_mem_addr;
  data_t [NE-1:0] eng_mem_wdata;
  logic [NE-1:0]  eng_mem_gnt;
  data_t [NE-1:0] eng_mem_rdata;
  logic [NE-1:0]  eng_mem_rvalid;
  logic [NE-1:0]  eng_busy;
  logic [NE-1:0]  eng_done;

  for (genvar i = 0; i < NE; i++) begin : gen_eng
    hwpe_reduce_engine u_eng (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .test_mode_i  (test_mode_i),
      .en_i         (eng_en[i]),
      .cfg_req_i    (eng_cfg_req[i]),
      .cfg_we_i     (eng_cfg_we[i]),
      .cfg_addr_i   (eng_cfg_addr[i]),
      .cfg_wdata_i  (eng_cfg_wdata[i]),
      .cfg_id_i     (eng_cfg_id[i]),
      .cfg_gnt_o    (eng_cfg_gnt[i]),
      .cfg_rdata_o  (eng_cfg_rdata[i]),
      .cfg_rvalid_o (eng_cfg_rvalid[i]),
      .cfg_rid_o    (eng_cfg_rid[i]),
      .mem_req_o    (eng_mem_req[i]),
      .mem_we_o     (eng_mem_we[i]),
      .mem_addr_o   (eng_mem_addr[i]),
      .mem_wdata_o  (eng_mem_wdata[i]),
      .mem_gnt_i    (eng_mem_gnt[i]),
      .mem_rdata_i  (eng_mem_rdata[i]),
      .mem_rvalid_i (eng_mem_rvalid[i]),
      .busy_o       (eng_busy[i]),
      .done_o       (eng_done[i])
    );
  end

  hwpe_sel_router u_router (
    .hwpe_en_i        (hwpe_en_i),
    .hwpe_sel_i       (hwpe_sel_i),
    .cfg_req_i        (cfg_req_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .cfg_id_i         (cfg_id_i),
    .cfg_gnt_o        (cfg_gnt_o),
    .cfg_rdata_o      (cfg_rdata_o),
    .cfg_rvalid_o     (cfg_rvalid_o),
    .cfg_rid_o        (cfg_rid_o),
    .mem_req_o        (mem_req_o),
    .mem_we_o         (mem_we_o),
    .mem_addr_o       (mem_addr_o),
    .mem_wdata_o      (mem_wdata_o),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .evt_o            (evt_o),
    .busy_o           (busy_o),
    .eng_en_o         (eng_en),
    .eng_cfg_req_o    (eng_cfg_req),
    .eng_cfg_we_o     (eng_cfg_we),
    .eng_cfg_addr_o   (eng_cfg_addr),
    .eng_cfg_wdata_o  (eng_cfg_wdata),
    .eng_cfg_id_o     (eng_cfg_id),
    .eng_cfg_gnt_i    (eng_cfg_gnt),
    .eng_cfg_rdata_i  (eng_cfg_rdata),
    .eng_cfg_rvalid_i (eng_cfg_rvalid),
    .eng_cfg_rid_i    (eng_cfg_rid),
    .eng_mem_req_i    (eng_mem_req),
    .eng_mem_we_i     (eng_mem_we),
    .eng_mem_addr_i   (eng_mem_addr),
    .eng_mem_wdata_i  (eng_mem_wdata),
    .eng_busy_i       (eng_busy),
    .eng_done_i       (eng_done),
    .eng_mem_gnt_o    (eng_mem_gnt),
    .eng_mem_rdata_o  (eng_mem_rdata),
    .eng_mem_rvalid_o (eng_mem_rvalid)
  );

endmodule

//--- tb_clk_gen.sv
// Clock and reset source for the HWPE subsystem testbench
// 100 ns clock, reset held low for five cycles and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_hwpe_subsystem.sv
// Testbench for the HWPE subsystem
// Runs a job table on both engines against a behavioral memory with random
// grant delays, checks results, done events, status and register readback
`timescale 1ns/1ps
`include "hwpe_cfg.svh"

module tb_hwpe_subsystem;

  import hwpe_bus_pkg::*;
  import hwpe_job_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int NUM_ROWS     = 8;
  localparam int MAX_LEN      = 12;
  localparam int NE           = `HWPE_NUM_ENGINES;
  // Budget of the longest job for every row, then reset
  localparam int WATCHDOG_CYCLES = NUM_ROWS * (MAX_LEN + 8) * 4 + RESET_CYCLES;

  typedef struct packed {
    sel_t       eng;
    opcode_e    op;
    addr_t      src;
    logic [7:0] len;
    addr_t      dst;
  } job_t;

  logic clk;
  logic rst_n;
  logic test_mode_i;
  logic hwpe_en_i;
  sel_t hwpe_sel_i;
  logic cfg_req_i;
  logic cfg_we_i;
  addr_t cfg_addr_i;
  data_t cfg_wdata_i;
  id_t cfg_id_i;
  logic cfg_gnt_o;
  data_t cfg_rdata_o;
  logic cfg_rvalid_o;
  id_t cfg_rid_o;
  logic mem_req_o;
  logic mem_we_o;
  addr_t mem_addr_o;
  data_t mem_wdata_o;
  logic mem_gnt_i = 1'b0;
  data_t mem_rdata_i = '0;
  logic mem_rvalid_i = 1'b0;
  evt_t [`HWPE_N_CORES-1:0] evt_o;
  logic busy_o;

  data_t mem [0:255];
  job_t jobs [NUM_ROWS];
  logic [31:0] rng_state = 32'd94;
  int errors;
  int test_err_base;
  int test_num;
  int n_pass;
  int n_fail;
  id_t next_id;

  // What each engine should hold
  addr_t sh_src [NE];
  logic [7:0] sh_len [NE];
  addr_t sh_dst [NE];
  logic [7:0] sh_jobs [NE];
  opcode_e sh_op [NE];

  // Memory model state and what the running job should produce
  addr_t exp_rd_addr;
  addr_t exp_dst;
  data_t exp_result;
  int rd_count;
  int wr_count;
  int gnt_dly = -1;
  logic rd_pending = 1'b0;
  data_t rd_word;

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  hwpe_subsystem u_dut (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .test_mode_i  (test_mode_i),
    .hwpe_en_i    (hwpe_en_i),
    .hwpe_sel_i   (hwpe_sel_i),
    .cfg_req_i    (cfg_req_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_id_i     (cfg_id_i),
    .cfg_gnt_o    (cfg_gnt_o),
    .cfg_rdata_o  (cfg_rdata_o),
    .cfg_rvalid_o (cfg_rvalid_o),
    .cfg_rid_o    (cfg_rid_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .evt_o        (evt_o),
    .busy_o       (busy_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // SUM wraps at 32 bits, MAX is unsigned, zero words give zero
  function automatic data_t reduce_expected(input opcode_e op, input addr_t src,
                                            input logic [7:0] len);
    data_t acc;
    data_t w;
    acc = '0;
    for (int i = 0; i < int'(len); i++) begin
      w = mem[src[9:2] + 8'(i)];
      case (op)
        SUM:     acc = acc + w;
        XOR:     acc = acc ^ w;
        default: acc = (w > acc) ? w : acc;
      endcase
    end
    return acc;
  endfunction

  // Status view with count in bits 10..3, last opcode in 2..1 and busy in 0
  function automatic data_t status_word(input int e);
    return {21'd0, sh_jobs[e], sh_op[e], 1'b0};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        errors++;
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
      else begin
        $display("Error at %0t ns: %s", $time, what);
        errors++;
      end
  endtask

  task automatic end_test(input string what);
    test_num++;
    if (errors == test_err_base) begin
      n_pass++;
      $display("test %0d %s: pass", test_num, what);
    end else begin
      n_fail++;
      $display("test %0d %s: fail", test_num, what);
    end
    test_err_base = errors;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Config bus transactions
  //////////////////////////////////////////////////////////////////////////

  // Ends on the falling edge right after the response cycle
  task automatic cfg_access(input logic we, input reg_idx_e idx, input data_t wdata,
                            input data_t exp_rd);
    id_t id;
    @(negedge clk);
    check_eq("cfg_rvalid_o", 32'd0, 32'(cfg_rvalid_o));
    id          = next_id;
    next_id     = next_id + id_t'(1);
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr_t'({idx, 2'b00});
    cfg_wdata_i = wdata;
    cfg_id_i    = id;
    @(posedge clk);
    check_eq("cfg_gnt_o", 32'd1, 32'(cfg_gnt_o));
    @(negedge clk);
    cfg_req_i = 1'b0;
    check_eq("cfg_rvalid_o", 32'd1, 32'(cfg_rvalid_o));
    check_eq("cfg_rid_o", 32'(id), 32'(cfg_rid_o));
    if (!we) begin
      check_eq($sformatf("cfg_rdata_o %s", idx.name()), exp_rd, cfg_rdata_o);
    end
  endtask

  task automatic cfg_write(input reg_idx_e idx, input data_t wdata);
    cfg_access(1'b1, idx, wdata, '0);
  endtask

  task automatic cfg_read(input reg_idx_e idx, input data_t exp_rd);
    cfg_access(1'b0, idx, '0, exp_rd);
  endtask

  task automatic select_engine(input sel_t e);
    @(negedge clk);
    hwpe_sel_i = e;
  endtask

  task automatic check_engine_regs(input int e);
    cfg_read(REG_SRC, sh_src[e]);
    cfg_read(REG_LEN, data_t'(sh_len[e]));
    cfg_read(REG_DST, sh_dst[e]);
    cfg_read(REG_CMD, status_word(e));
  endtask

  task automatic run_job(input job_t j);
    int e;
    int cycles;
    int pulses;
    logic finished;
    e = int'(j.eng);
    select_engine(j.eng);
    cfg_write(REG_SRC, j.src);
    cfg_write(REG_LEN, data_t'(j.len));
    cfg_write(REG_DST, j.dst);
    sh_src[e]   = j.src;
    sh_len[e]   = j.len;
    sh_dst[e]   = j.dst;
    exp_rd_addr = j.src;
    exp_dst     = j.dst;
    exp_result  = reduce_expected(j.op, j.src, j.len);
    rd_count    = 0;
    wr_count    = 0;
    cfg_write(REG_CMD, {29'd0, j.op, 1'b1});
    // Now one falling edge past the cycle that took the start
    check_eq("busy_o", 32'd1, 32'(busy_o));
    cycles    = 0;
    pulses    = 0;
    finished  = 1'b0;
    while (!finished && cycles < (int'(j.len) + 8) * 8) begin
      @(negedge clk);
      cycles++;
      if (evt_o != '0) begin
        pulses++;
        check_eq("evt_o", 32'h55, 32'(evt_o));
        check_eq("busy_o", 32'd0, 32'(busy_o));
      end
      finished = !busy_o;
    end
    check_true(finished, "job did not finish within its cycle budget");
    @(negedge clk);
    check_eq("evt_o", 32'd0, 32'(evt_o));
    check_true(pulses == 1, $sformatf("expected one done event, saw %0d", pulses));
    check_eq("read count", 32'(j.len), 32'(rd_count));
    check_eq("write count", 32'd1, 32'(wr_count));
    sh_jobs[e] = sh_jobs[e] + 8'd1;
    sh_op[e]   = j.op;
    cfg_read(REG_CMD, status_word(e));
  endtask

  task automatic set_row(input int r, input sel_t eng, input opcode_e op, input addr_t src,
                         input logic [7:0] len, input addr_t dst);
    jobs[r] = '{eng: eng, op: op, src: src, len: len, dst: dst};
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles and read data one cycle after the grant
  always @(negedge clk) begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = rd_pending;
    mem_rdata_i  = rd_pending ? rd_word : '0;
    rd_pending   = 1'b0;
    if (rst_n && mem_req_o) begin
      if (gnt_dly < 0) begin
        rng_state = xorshift32(rng_state);
        gnt_dly   = int'(rng_state[1:0]);
      end
      if (gnt_dly == 0) begin
        mem_gnt_i = 1'b1;
        gnt_dly   = -1;
        if (mem_we_o) begin
          check_eq("mem_addr_o", exp_dst, mem_addr_o);
          check_eq("mem_wdata_o", exp_result, mem_wdata_o);
          mem[mem_addr_o[9:2]] = mem_wdata_o;
          wr_count++;
        end else begin
          check_eq("mem_addr_o", exp_rd_addr, mem_addr_o);
          exp_rd_addr = exp_rd_addr + 32'd4;
          rd_word     = mem[mem_addr_o[9:2]];
          rd_pending  = 1'b1;
          rd_count++;
        end
      end else begin
        gnt_dly--;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    test_mode_i   = 1'b0;
    hwpe_en_i     = 1'b1;
    hwpe_sel_i    = '0;
    cfg_req_i     = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    cfg_id_i      = '0;
    next_id       = '0;
    errors        = 0;
    test_err_base = 0;
    test_num      = 0;
    n_pass        = 0;
    n_fail        = 0;
    for (int i = 0; i < 256; i++) begin
      rng_state = xorshift32(rng_state);
      mem[i]    = rng_state ^ {22'd0, i[7:0], 2'b00};
    end
    for (int e = 0; e < NE; e++) begin
      sh_jobs[e] = '0;
      sh_op[e]   = SUM;
    end
    // Sources stay below 0x380 and results land above it
    set_row(0, 1'b0, SUM, 32'h000, 8'd8,  32'h380);
    set_row(1, 1'b1, XOR, 32'h040, 8'd5,  32'h384);
    set_row(2, 1'b0, MAX, 32'h080, 8'd12, 32'h388);
    set_row(3, 1'b1, SUM, 32'h100, 8'd0,  32'h38C);
    set_row(4, 1'b0, XOR, 32'h0C0, 8'd1,  32'h390);
    set_row(5, 1'b1, MAX, 32'h200, 8'd10, 32'h394);
    set_row(6, 1'b1, SUM, 32'h1C0, 8'd7,  32'h398);
    set_row(7, 1'b0, MAX, 32'h240, 8'd3,  32'h39C);

    @(posedge rst_n);
    check_eq("busy_o", 32'd0, 32'(busy_o));
    check_eq("mem_req_o", 32'd0, 32'(mem_req_o));
    check_eq("cfg_rvalid_o", 32'd0, 32'(cfg_rvalid_o));
    check_eq("evt_o", 32'd0, 32'(evt_o));
    end_test("reset state");

    for (int e = 0; e < NE; e++) begin
      select_engine(sel_t'(e));
      sh_src[e] = 32'hA000_0040 + 32'(e) * 32'h100;
      sh_len[e] = 8'h30 + 8'(e);
      sh_dst[e] = 32'hB000_0080 + 32'(e) * 32'h10;
      cfg_write(REG_SRC, sh_src[e]);
      cfg_write(REG_LEN, data_t'(sh_len[e]));
      cfg_write(REG_DST, sh_dst[e]);
      check_engine_regs(e);
    end
    end_test("register readback");

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_job(jobs[r]);
      end_test($sformatf("job %0d engine %0d %s len %0d", r, jobs[r].eng,
                         jobs[r].op.name(), jobs[r].len));
    end

    // Neither engine may have picked up state from the other
    for (int e = 0; e < NE; e++) begin
      select_engine(sel_t'(e));
      check_engine_regs(e);
    end
    end_test("engine isolation");

    $display("%0d tests, %0d passed, %0d failed, %0d failed checks",
             test_num, n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
hwpe_bus_pkg.sv
hwpe_job_pkg.sv
hwpe_ctrl_fsm.sv
hwpe_word_counter.sv
hwpe_reduce_engine.sv
hwpe_sel_router.sv
hwpe_subsystem.sv
tb_clk_gen.sv
tb_hwpe_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_hwpe_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
